// File: design/core6502_consts.svh
// Bus widths, reset vector addresses, PC reset value and flag bit positions
`ifndef CORE6502_CONSTS_SVH
`define CORE6502_CONSTS_SVH

// Bus widths
`define ADDR_WIDTH 16
`define DATA_WIDTH 8

// Reset vector, low byte first
`define RESET_VECTOR_LO 16'hFFFC
`define RESET_VECTOR_HI 16'hFFFD

// PC is overwritten by the vector fetch before first use
`define PC_RESET_VALUE 16'h0000

// Positions inside the flags bus
`define FLAGS_WIDTH 4
`define FLAG_N 3
`define FLAG_Z 2
`define FLAG_C 1
`define FLAG_V 0

`endif

// File: design/core6502_pkg.sv
// Opcode, sequencer state, ALU operation and address source types
package core6502_pkg;

	// Supported opcodes, anything else decodes as NOP
	typedef enum logic [7:0] {
		OP_LDA_IMM = 8'hA9,
		OP_LDX_IMM = 8'hA2,
		OP_LDY_IMM = 8'hA0,
		OP_ADC_IMM = 8'h69,
		OP_SBC_IMM = 8'hE9,
		OP_AND_IMM = 8'h29,
		OP_ORA_IMM = 8'h09,
		OP_EOR_IMM = 8'h49,
		OP_STA_ABS = 8'h8D,
		OP_JMP_ABS = 8'h4C,
		OP_CLC     = 8'h18,
		OP_SEC     = 8'h38,
		OP_TAX     = 8'hAA,
		OP_INX     = 8'hE8,
		OP_NOP     = 8'hEA
	} opcode_t;

	// Sequencer cycles
	typedef enum logic [2:0] {
		VEC0, // Vector low byte
		VEC1, // Vector high byte
		T1,   // Opcode fetch
		T2,   // Operand fetch or implied execute
		T3,   // Address high byte
		T4    // Write
	} tState_t;

	typedef enum logic [3:0] {
		PASS,
		ADC,
		SBC,
		AND,
		ORA,
		EOR,
		INC,
		CLC,
		SEC
	} aluOp_t;

	// Address bus source
	typedef enum logic [1:0] {
		SRC_PC,    // Program counter
		SRC_LATCH, // Absolute address from data latch
		SRC_VEC    // Reset vector
	} addrSrc_t;

endpackage

// File: design/CoreCtrlIf.sv
// Control command bundle from the sequencer to the ALU and register datapath
interface CoreCtrlIf
	import core6502_pkg::*;
();

	aluOp_t   aluOp;   // ALU operation select
	logic     aluEn;   // Write A and flags
	logic     loadX;   // X <= ALU result
	logic     loadY;   // Y <= ALU result
	logic     xferAX;  // X <= A
	logic     incX;    // X <= X + 1
	logic     pcInc;
	logic     pcLoad;  // PC <= {dataIn, latch low}
	logic     latchLo; // Capture dataIn into latch low byte
	logic     latchHi; // Capture dataIn into latch high byte
	addrSrc_t addrSrc;
	logic     vecSel;  // 0 selects vector low, 1 high
	logic     writeA;  // A on dataOut, write cycle

	modport seq (
		output aluOp, aluEn, loadX, loadY, xferAX, incX, pcInc, pcLoad,
		output latchLo, latchHi, addrSrc, vecSel, writeA
	);

	modport dp (
		input aluOp, aluEn, loadX, loadY, xferAX, incX, pcInc, pcLoad,
		input latchLo, latchHi, addrSrc, vecSel, writeA
	);

endinterface

// File: design/Dispatch.sv
// T-state sequencer and instruction decoder driving the per-cycle control commands
`include "core6502_consts.svh"

module Dispatch
	import core6502_pkg::*;
(
	input  logic                   phi0,
	input  logic                   reset,
	input  logic                   rdy,
	input  logic [`DATA_WIDTH-1:0] opcode, // Raw opcode byte from the bus
	CoreCtrlIf.seq                 ctrl,
	output logic                   rnW,
	output logic                   sync
);

	tState_t state;
	tState_t stateNext;
	opcode_t opcodeReg;  // Instruction in flight
	opcode_t opcodeNext; // Fetched byte, unknown folded to NOP

	// Known opcodes pass, everything else runs as NOP
	always_comb begin
		case (opcode)
			OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_ADC_IMM, OP_SBC_IMM,
			OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM, OP_STA_ABS, OP_JMP_ABS,
			OP_CLC, OP_SEC, OP_TAX, OP_INX, OP_NOP:
				opcodeNext = opcode_t'(opcode);
			default: opcodeNext = OP_NOP;
		endcase
	end

	always_comb begin
		case (state)
			VEC0: stateNext = VEC1;
			VEC1: stateNext = T1;
			T1:   stateNext = T2;
			T2:   stateNext = (opcodeReg == OP_STA_ABS || opcodeReg == OP_JMP_ABS) ? T3 : T1;
			T3:   stateNext = (opcodeReg == OP_STA_ABS) ? T4 : T1;
			default: stateNext = T1; // T4 ends STA
		endcase
	end

	always_ff @(posedge phi0) begin
		if (reset) begin
			state <= VEC0;
			opcodeReg <= OP_NOP; // Nothing pending at first T1
		end else if (rdy) begin
			state <= stateNext;
			if (state == T1)
				opcodeReg <= opcodeNext; // Opcode byte ends T1
		end
	end

	// Command decode from state and latched opcode
	always_comb begin
		ctrl.aluOp = PASS;
		ctrl.aluEn = 1'b0;
		ctrl.loadX = 1'b0;
		ctrl.loadY = 1'b0;
		ctrl.xferAX = 1'b0;
		ctrl.incX = 1'b0;
		ctrl.pcInc = 1'b0;
		ctrl.pcLoad = 1'b0;
		ctrl.latchLo = 1'b0;
		ctrl.latchHi = 1'b0;
		ctrl.addrSrc = SRC_PC;
		ctrl.vecSel = 1'b0;
		ctrl.writeA = 1'b0;
		case (state)
			VEC0: begin
				ctrl.addrSrc = SRC_VEC;
				ctrl.latchLo = 1'b1;
			end
			VEC1: begin
				ctrl.addrSrc = SRC_VEC;
				ctrl.vecSel = 1'b1;
				ctrl.latchHi = 1'b1;
				ctrl.pcLoad = 1'b1; // Jump to vector
			end
			T1: begin
				ctrl.pcInc = 1'b1;
				// Immediate ops finish here, overlapped with the next fetch
				case (opcodeReg)
					OP_LDA_IMM: ctrl.aluEn = 1'b1;
					OP_LDX_IMM: ctrl.loadX = 1'b1;
					OP_LDY_IMM: ctrl.loadY = 1'b1;
					OP_ADC_IMM: begin
						ctrl.aluOp = ADC;
						ctrl.aluEn = 1'b1;
					end
					OP_SBC_IMM: begin
						ctrl.aluOp = SBC;
						ctrl.aluEn = 1'b1;
					end
					OP_AND_IMM: begin
						ctrl.aluOp = AND;
						ctrl.aluEn = 1'b1;
					end
					OP_ORA_IMM: begin
						ctrl.aluOp = ORA;
						ctrl.aluEn = 1'b1;
					end
					OP_EOR_IMM: begin
						ctrl.aluOp = EOR;
						ctrl.aluEn = 1'b1;
					end
					default: ;
				endcase
			end
			T2: begin
				case (opcodeReg)
					OP_CLC: begin
						ctrl.aluOp = CLC;
						ctrl.aluEn = 1'b1;
					end
					OP_SEC: begin
						ctrl.aluOp = SEC;
						ctrl.aluEn = 1'b1;
					end
					OP_TAX: ctrl.xferAX = 1'b1;
					OP_INX: ctrl.incX = 1'b1;
					OP_NOP: ; // Dummy read at PC
					default: begin
						ctrl.pcInc = 1'b1; // Operand or address low byte
						ctrl.latchLo = 1'b1;
					end
				endcase
			end
			T3: begin
				ctrl.latchHi = 1'b1;
				if (opcodeReg == OP_JMP_ABS)
					ctrl.pcLoad = 1'b1;
				else
					ctrl.pcInc = 1'b1;
			end
			default: begin
				ctrl.addrSrc = SRC_LATCH; // STA target
				ctrl.writeA = 1'b1;
			end
		endcase
	end

	assign sync = (state == T1);
	assign rnW = ~ctrl.writeA;

	// An opcode fetch is never a write
	assert property (@(posedge phi0) disable iff (reset) sync |-> rnW);

	// Writes only come from the last cycle of STA
	assert property (@(posedge phi0) disable iff (reset)
		!rnW |-> (state == T4 && opcodeReg == OP_STA_ABS));

endmodule

// File: design/Alu.sv
// ALU function unit and N, Z, C, V flag register
`include "core6502_consts.svh"

module Alu
	import core6502_pkg::*;
(
	input  logic                    phi0,
	input  logic                    reset,
	input  logic                    rdy,
	CoreCtrlIf.dp                   ctrl,
	input  logic [`DATA_WIDTH-1:0]  accIn,
	input  logic [`DATA_WIDTH-1:0]  operand,  // Data latch low byte
	output logic [`DATA_WIDTH-1:0]  aluResult,
	output logic [`FLAGS_WIDTH-1:0] flags
);

	logic                 n;
	logic                 z;
	logic                 c;
	logic                 v;
	logic [`DATA_WIDTH-1:0] addend;   // Operand, inverted for SBC
	logic [`DATA_WIDTH:0]   sum;      // Extra bit is carry out
	logic                 overflow;
	logic [`DATA_WIDTH-1:0] nzValue;  // Value that sets N and Z

	// SBC is A + ~M + C, carry acts as inverted borrow
	assign addend = (ctrl.aluOp == SBC) ? ~operand : operand;
	assign sum = {1'b0, accIn} + {1'b0, addend} + {{`DATA_WIDTH{1'b0}}, c};

	// Signed overflow when both inputs agree and the result sign differs
	assign overflow = (accIn[`DATA_WIDTH-1] == addend[`DATA_WIDTH-1])
		&& (sum[`DATA_WIDTH-1] != accIn[`DATA_WIDTH-1]);

	always_comb begin
		case (ctrl.aluOp)
			ADC, SBC: aluResult = sum[`DATA_WIDTH-1:0];
			AND:      aluResult = accIn & operand;
			ORA:      aluResult = accIn | operand;
			EOR:      aluResult = accIn ^ operand;
			INC:      aluResult = operand + 1'b1;
			CLC, SEC: aluResult = accIn; // A rewritten unchanged
			default:  aluResult = operand; // PASS for loads
		endcase
	end

	// TAX takes N and Z from A itself
	assign nzValue = ctrl.xferAX ? accIn : aluResult;

	always_ff @(posedge phi0) begin
		if (reset) begin
			n <= 1'b0;
			z <= 1'b0;
			c <= 1'b0;
			v <= 1'b0;
		end else if (rdy) begin
			if (ctrl.aluEn) begin
				case (ctrl.aluOp)
					CLC: c <= 1'b0; // Carry only
					SEC: c <= 1'b1;
					default: begin
						n <= nzValue[`DATA_WIDTH-1];
						z <= (nzValue == '0);
						if (ctrl.aluOp == ADC || ctrl.aluOp == SBC) begin
							c <= sum[`DATA_WIDTH];
							v <= overflow;
						end
					end
				endcase
			end else if (ctrl.loadX || ctrl.loadY || ctrl.xferAX) begin
				n <= nzValue[`DATA_WIDTH-1]; // Index loads touch N, Z
				z <= (nzValue == '0);
			end
		end
	end

	assign flags[`FLAG_N] = n;
	assign flags[`FLAG_Z] = z;
	assign flags[`FLAG_C] = c;
	assign flags[`FLAG_V] = v;

	// Stalled core keeps its flags
	assert property (@(posedge phi0) disable iff (reset) !rdy |=> $stable(flags));

endmodule

// File: design/Regs.sv
// A, X, Y, program counter, data latch and bus output selection
`include "core6502_consts.svh"

module Regs
	import core6502_pkg::*;
(
	input  logic                   phi0,
	input  logic                   reset,
	input  logic                   rdy,
	CoreCtrlIf.dp                  ctrl,
	input  logic [`DATA_WIDTH-1:0] dataIn,
	input  logic [`DATA_WIDTH-1:0] aluResult,
	output logic [`DATA_WIDTH-1:0] accOut,
	output logic [`DATA_WIDTH-1:0] latchOut,
	output logic [`DATA_WIDTH-1:0] opcode,
	output logic [`ADDR_WIDTH-1:0] addr,
	output logic [`DATA_WIDTH-1:0] dataOut
);

	logic [`DATA_WIDTH-1:0] a;
	logic [`DATA_WIDTH-1:0] x;
	logic [`DATA_WIDTH-1:0] y;
	logic [`ADDR_WIDTH-1:0] pc;
	logic [`DATA_WIDTH-1:0] dataLo; // Operand or address low
	logic [`DATA_WIDTH-1:0] dataHi; // Address high

	always_ff @(posedge phi0) begin
		if (reset) begin
			a <= '0;
			x <= '0;
			y <= '0;
			pc <= `PC_RESET_VALUE;
		end else if (rdy) begin
			if (ctrl.aluEn)
				a <= aluResult;
			if (ctrl.loadX)
				x <= aluResult;
			else if (ctrl.xferAX)
				x <= a;
			else if (ctrl.incX)
				x <= x + 1'b1;
			if (ctrl.loadY)
				y <= aluResult;
			// High byte comes straight off the bus in the same cycle
			if (ctrl.pcLoad)
				pc <= {dataIn, dataLo};
			else if (ctrl.pcInc)
				pc <= pc + 1'b1;
		end
	end

	// Data latch
	always_ff @(posedge phi0) begin
		if (rdy) begin
			if (ctrl.latchLo)
				dataLo <= dataIn;
			if (ctrl.latchHi)
				dataHi <= dataIn;
		end
	end

	always_comb begin
		case (ctrl.addrSrc)
			SRC_LATCH: addr = {dataHi, dataLo};
			SRC_VEC:   addr = ctrl.vecSel ? `RESET_VECTOR_HI : `RESET_VECTOR_LO;
			default:   addr = pc;
		endcase
	end

	assign dataOut = ctrl.writeA ? a : '0; // Zero outside write cycles
	assign accOut = a;
	assign latchOut = dataLo;
	assign opcode = dataIn; // Sequencer picks it up at T1

endmodule

// File: design/Core6502.sv
// Top level, sequencer, ALU and registers on one memory bus
`include "core6502_consts.svh"

module Core6502 (
	input  logic                    phi0,    // Single core clock
	input  logic                    reset,   // Synchronous, active high
	input  logic                    rdy,     // Low stalls the whole core
	input  logic [`DATA_WIDTH-1:0]  dataIn,  // Read data
	output logic                    rnW,     // 1 read, 0 write
	output logic                    sync,    // Opcode fetch cycle
	output logic [`ADDR_WIDTH-1:0]  addr,
	output logic [`DATA_WIDTH-1:0]  dataOut, // Write data
	output logic [`FLAGS_WIDTH-1:0] flags    // N, Z, C, V
);

	logic [`DATA_WIDTH-1:0] accA;
	logic [`DATA_WIDTH-1:0] dataLatch;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic [`DATA_WIDTH-1:0] opcodeByte;

	CoreCtrlIf ctrl ();

	Dispatch disp (
		.phi0(phi0),
		.reset(reset),
		.rdy(rdy),
		.opcode(opcodeByte),
		.ctrl(ctrl.seq),
		.rnW(rnW),
		.sync(sync)
	);

	Alu alu (
		.phi0(phi0),
		.reset(reset),
		.rdy(rdy),
		.ctrl(ctrl.dp),
		.accIn(accA),
		.operand(dataLatch),
		.aluResult(aluResult),
		.flags(flags)
	);

	Regs regs (
		.phi0(phi0),
		.reset(reset),
		.rdy(rdy),
		.ctrl(ctrl.dp),
		.dataIn(dataIn),
		.aluResult(aluResult),
		.accOut(accA),
		.latchOut(dataLatch),
		.opcode(opcodeByte),
		.addr(addr),
		.dataOut(dataOut)
	);

endmodule

// File: tb/tbMemModel.sv
// 64 KiB memory model with random ready stalls, write and fetch logs and byte loading
`include "core6502_consts.svh"

module tbMemModel (
	input  logic                   phi0,
	input  logic                   stallEn, // Random rdy drops when high
	input  logic [`ADDR_WIDTH-1:0] addr,
	input  logic                   rnW,
	input  logic                   sync,
	input  logic [`DATA_WIDTH-1:0] dataOut,
	output logic                   rdy,
	output logic [`DATA_WIDTH-1:0] dataIn
);

	logic [`DATA_WIDTH-1:0] bytes [0:(1 << `ADDR_WIDTH)-1];
	logic [`ADDR_WIDTH+`DATA_WIDTH-1:0] writeLog [$]; // {addr, data} per completed write
	logic [`ADDR_WIDTH-1:0] fetchLog [$];               // Completed opcode fetch addresses
	logic                   rdyQ = 1'b1;
	logic [`DATA_WIDTH-1:0] dataQ = '0;
	logic                   nextRdy;

	assign rdy = rdyQ;
	assign dataIn = dataQ;

	task automatic loadByte(input logic [`ADDR_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] d);
		bytes[a] = d;
	endtask

	task automatic clearLogs();
		writeLog.delete();
		fetchLog.delete();
	endtask

	// Bus outputs are stable here, the cycle ends at the next rising edge
	always @(negedge phi0) begin
		nextRdy = !stallEn || ($urandom_range(0, 9) > 2); // Roughly 30 percent stalls
		if (nextRdy && !rnW) begin
			writeLog.push_back({addr, dataOut}); // Completes with this rdy
			bytes[addr] = dataOut;
		end
		if (nextRdy && sync)
			fetchLog.push_back(addr);
		rdyQ <= nextRdy;
		dataQ <= bytes[addr]; // Address holds until the next rising edge
	end

endmodule

// File: tb/tbCore6502.sv
// Testbench top with clock, reset, program builders, reference model and checkers
`include "core6502_consts.svh"

module tbCore6502
	import core6502_pkg::*;
();

	localparam int RUN_TIMEOUT = 5000; // Cycles per program

	logic                    phi0;
	logic                    reset;
	logic                    stallEn;
	logic                    rdy;
	logic [`DATA_WIDTH-1:0]  dataIn;
	logic                    rnW;
	logic                    sync;
	logic [`ADDR_WIDTH-1:0]  addr;
	logic [`DATA_WIDTH-1:0]  dataOut;
	logic [`FLAGS_WIDTH-1:0] flags;

	logic [7:0]  image [0:65535]; // Program image seen by the reference
	logic [15:0] pcBuild;         // Next free byte for the builders
	logic [23:0] expWrites [$];   // {addr, data}
	logic [15:0] expFetches [$];
	logic [23:0] actualWrites [$];
	logic [23:0] baseline [$];    // Writes of a stall-free run
	logic [23:0] gotW;
	logic [23:0] wantW;
	logic [15:0] gotF;
	logic [15:0] wantF;
	logic [`FLAGS_WIDTH-1:0] expFlags; // N, Z, C, V once the halt loop is reached
	int          expFetchTotal = 0;
	int          fetchChecked = 0;
	int          checkCount = 0;
	int          errCount = 0;
	int          testCount = 0;
	logic [7:0]  unlistedOps [0:5] = '{8'h02, 8'h1A, 8'h80, 8'hFF, 8'hDB, 8'h44};

	Core6502 i_dut (
		.phi0(phi0),
		.reset(reset),
		.rdy(rdy),
		.dataIn(dataIn),
		.rnW(rnW),
		.sync(sync),
		.addr(addr),
		.dataOut(dataOut),
		.flags(flags)
	);

	tbMemModel memModel (
		.phi0(phi0),
		.stallEn(stallEn),
		.addr(addr),
		.rnW(rnW),
		.sync(sync),
		.dataOut(dataOut),
		.rdy(rdy),
		.dataIn(dataIn)
	);

	always #10 phi0 = ~phi0; // 20 unit period

	function automatic logic [7:0] randomByte();
		return 8'($urandom());
	endfunction

	// Sign and zero of a result byte
	function automatic logic [1:0] nzOf(input logic [7:0] val);
		return {val[7], val == 8'h00};
	endfunction

	task automatic putByte(input logic [15:0] a, input logic [7:0] d);
		image[a] = d;
	endtask

	task automatic beginProgram(input logic [15:0] vector);
		for (int i = 0; i < 65536; i++)
			image[i] = 8'(i) ^ 8'(i >> 8); // Background from both address bytes
		putByte(`RESET_VECTOR_LO, vector[7:0]);
		putByte(`RESET_VECTOR_HI, vector[15:8]);
		pcBuild = vector;
	endtask

	task automatic emitRaw(input logic [7:0] b);
		putByte(pcBuild, b);
		pcBuild = pcBuild + 16'd1;
	endtask

	task automatic emitOp(input opcode_t op);
		emitRaw(op);
	endtask

	task automatic emitImm(input opcode_t op, input logic [7:0] imm);
		emitRaw(op);
		emitRaw(imm);
	endtask

	task automatic emitAbs(input opcode_t op, input logic [15:0] target);
		emitRaw(op);
		emitRaw(target[7:0]); // Little endian operand
		emitRaw(target[15:8]);
	endtask

	task automatic emitHalt();
		emitAbs(OP_JMP_ABS, pcBuild); // Jump to itself
	endtask

	// 6502 rules on the image, fills the expected fetch and write lists and flags
	function automatic void predictRun();
		logic [7:0]  a;
		logic [7:0]  x;
		logic [7:0]  res;
		logic [7:0]  op;
		logic [7:0]  b1;
		logic [7:0]  b2;
		logic [15:0] pc;
		logic [15:0] target;
		int          sum;
		bit          n;
		bit          z;
		bit          c;
		bit          v;
		bit          halted;
		int          steps;
		a = 8'h00;
		x = 8'h00;
		n = 1'b0;
		z = 1'b0;
		c = 1'b0;
		v = 1'b0;
		halted = 1'b0;
		steps = 0;
		pc = {image[`RESET_VECTOR_HI], image[`RESET_VECTOR_LO]};
		expWrites.delete();
		expFetches.delete();
		while (!halted && steps < 1000) begin
			op = image[pc];
			b1 = image[pc + 16'd1];
			b2 = image[pc + 16'd2];
			target = {b2, b1};
			expFetches.push_back(pc);
			steps++;
			case (op)
				OP_LDA_IMM: begin
					a = b1;
					{n, z} = nzOf(a);
					pc = pc + 16'd2;
				end
				OP_LDX_IMM: begin
					x = b1;
					{n, z} = nzOf(x);
					pc = pc + 16'd2;
				end
				OP_LDY_IMM: begin
					{n, z} = nzOf(b1); // Y itself never reaches the bus
					pc = pc + 16'd2;
				end
				OP_ADC_IMM: begin
					sum = int'(a) + int'(b1) + int'(c);
					res = 8'(sum);
					c = (sum > 255);
					v = ((a ^ res) & (b1 ^ res) & 8'h80) != 8'h00; // Both signs flipped
					a = res;
					{n, z} = nzOf(a);
					pc = pc + 16'd2;
				end
				OP_SBC_IMM: begin
					sum = int'(a) - int'(b1) - (c ? 0 : 1); // Clear carry borrows one
					res = 8'(sum);
					c = (sum >= 0);
					v = ((a ^ b1) & (a ^ res) & 8'h80) != 8'h00;
					a = res;
					{n, z} = nzOf(a);
					pc = pc + 16'd2;
				end
				OP_AND_IMM: begin
					a = a & b1;
					{n, z} = nzOf(a);
					pc = pc + 16'd2;
				end
				OP_ORA_IMM: begin
					a = a | b1;
					{n, z} = nzOf(a);
					pc = pc + 16'd2;
				end
				OP_EOR_IMM: begin
					a = a ^ b1;
					{n, z} = nzOf(a);
					pc = pc + 16'd2;
				end
				OP_STA_ABS: begin
					expWrites.push_back({target, a});
					pc = pc + 16'd3;
				end
				OP_JMP_ABS: begin
					if (target == pc)
						halted = 1'b1;
					pc = target;
				end
				OP_CLC: begin
					c = 1'b0;
					pc = pc + 16'd1;
				end
				OP_SEC: begin
					c = 1'b1;
					pc = pc + 16'd1;
				end
				OP_TAX: begin
					x = a;
					{n, z} = nzOf(x);
					pc = pc + 16'd1;
				end
				OP_INX: begin
					x = x + 8'd1;
					{n, z} = nzOf(x);
					pc = pc + 16'd1;
				end
				default: pc = pc + 16'd1; // NOP and unlisted bytes
			endcase
		end
		expFlags = '0;
		expFlags[`FLAG_N] = n;
		expFlags[`FLAG_Z] = z;
		expFlags[`FLAG_C] = c;
		expFlags[`FLAG_V] = v;
	endfunction

	// Compare logged bus cycles against the reference lists
	always @(posedge phi0) begin
		while (memModel.writeLog.size() > 0) begin
			gotW = memModel.writeLog.pop_front();
			actualWrites.push_back(gotW);
			checkCount++;
			assert (expWrites.size() > 0) else begin
				errCount++;
				$display("Unexpected write of %h to address %h", gotW[7:0], gotW[23:8]);
			end
			if (expWrites.size() > 0) begin
				wantW = expWrites.pop_front();
				assert (gotW[23:8] == wantW[23:8]) else begin
					errCount++;
					$display("[FAIL] addr: got %h, expected %h", gotW[23:8], wantW[23:8]);
				end
				assert (gotW[7:0] == wantW[7:0]) else begin
					errCount++;
					$display("[FAIL] dataOut: got %h, expected %h", gotW[7:0], wantW[7:0]);
				end
			end
		end
		while (memModel.fetchLog.size() > 0) begin
			gotF = memModel.fetchLog.pop_front();
			if (expFetches.size() > 0) begin // Later fetches spin in the halt loop
				wantF = expFetches.pop_front();
				fetchChecked++;
				checkCount++;
				assert (gotF == wantF) else begin
					errCount++;
					$display("[FAIL] addr at sync: got %h, expected %h", gotF, wantF);
				end
			end
		end
	end

	// Opcode fetch never overlaps a write
	always @(negedge phi0) begin
		if (!reset && !rnW) begin
			checkCount++;
			assert (!sync) else begin
				errCount++;
				$display("[FAIL] sync: got %h, expected 0 in write to %h", sync, addr);
			end
		end
	end

	task automatic runProgram(input bit stalls);
		int cycles;
		@(negedge phi0);
		reset = 1'b1;
		stallEn = stalls;
		@(negedge phi0); // Core sits in VEC0, bus idle
		memModel.clearLogs();
		for (int i = 0; i < 65536; i++)
			memModel.loadByte(16'(i), image[i]);
		predictRun();
		expFetchTotal = expFetches.size();
		fetchChecked = 0;
		actualWrites.delete();
		repeat (9) @(negedge phi0); // Reset spans 10 cycles
		checkCount++;
		assert (rnW && !sync && dataOut == '0 && addr == `RESET_VECTOR_LO) else begin
			errCount++;
			$display("[FAIL] reset bus: rnW %h sync %h addr %h dataOut %h, expected 1 0 fffc 00",
				rnW, sync, addr, dataOut);
		end
		reset = 1'b0;
		cycles = 0;
		while (fetchChecked < expFetchTotal && cycles < RUN_TIMEOUT) begin
			@(negedge phi0);
			cycles++;
		end
		assert (fetchChecked >= expFetchTotal) else begin
			errCount++;
			$display("Timeout: program did not reach its halt loop in %0d cycles", RUN_TIMEOUT);
		end
		checkCount++;
		assert (expWrites.size() == 0) else begin
			errCount++;
			$display("%0d expected writes never happened", expWrites.size());
		end
		checkCount++;
		assert (flags == expFlags) else begin // Halt loop leaves the flags alone
			errCount++;
			$display("[FAIL] flags: got %h, expected %h", flags, expFlags);
		end
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		testCount++;
		if (errCount == errsBefore)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errCount - errsBefore);
	endtask

	task automatic testVectorAndJump();
		int errsBefore;
		errsBefore = errCount;
		beginProgram(16'h0200);
		emitImm(OP_LDA_IMM, 8'h5A);
		emitAbs(OP_JMP_ABS, 16'h0300);
		emitAbs(OP_STA_ABS, 16'h1000); // Skipped by the jump
		pcBuild = 16'h0300;
		emitAbs(OP_STA_ABS, 16'h1001);
		emitHalt();
		runProgram(1'b1);
		reportTest("reset vector and jump", errsBefore);
	endtask

	task automatic testLoads();
		int errsBefore;
		errsBefore = errCount;
		beginProgram(16'h8000);
		emitImm(OP_LDA_IMM, randomByte());
		emitAbs(OP_STA_ABS, 16'h2000);
		emitImm(OP_LDX_IMM, randomByte());
		emitImm(OP_LDY_IMM, randomByte());
		emitImm(OP_LDA_IMM, randomByte());
		emitOp(OP_TAX);
		emitOp(OP_INX);
		emitOp(OP_NOP);
		emitAbs(OP_STA_ABS, 16'h2001); // A survives the index ops
		emitImm(OP_LDA_IMM, 8'h00);
		emitAbs(OP_STA_ABS, 16'h2002);
		emitHalt();
		runProgram(1'b1);
		reportTest("loads and transfers", errsBefore);
	endtask

	task automatic testAlu();
		int          errsBefore;
		int          pick;
		logic [15:0] dst;
		opcode_t     arith;
		opcode_t     logicOp;
		errsBefore = errCount;
		beginProgram(16'h0400);
		dst = 16'h3000;
		for (int i = 0; i < 8; i++) begin
			if ($urandom_range(0, 1) == 1)
				emitOp(OP_SEC);
			else
				emitOp(OP_CLC);
			if (i % 2 == 1)
				arith = OP_SBC_IMM;
			else
				arith = OP_ADC_IMM;
			pick = $urandom_range(0, 2);
			case (pick)
				0: logicOp = OP_AND_IMM;
				1: logicOp = OP_ORA_IMM;
				default: logicOp = OP_EOR_IMM;
			endcase
			emitImm(OP_LDA_IMM, randomByte());
			emitImm(arith, randomByte());
			emitAbs(OP_STA_ABS, dst);
			emitImm(OP_ADC_IMM, 8'h00); // Adds the carry left by the step before
			emitAbs(OP_STA_ABS, dst + 16'd1);
			emitImm(logicOp, randomByte());
			emitAbs(OP_STA_ABS, dst + 16'd2);
			dst = dst + 16'd3;
		end
		emitHalt();
		runProgram(1'b0);
		baseline = actualWrites;
		runProgram(1'b1); // Same program under back-pressure
		checkCount++;
		assert (actualWrites.size() == baseline.size()) else begin
			errCount++;
			$display("[FAIL] write count: got %h, expected %h", actualWrites.size(), baseline.size());
		end
		foreach (baseline[k]) begin
			if (k < actualWrites.size()) begin
				checkCount++;
				assert (actualWrites[k] == baseline[k]) else begin
					errCount++;
					$display("[FAIL] writeLog[%0d]: got %h, expected %h", k, actualWrites[k], baseline[k]);
				end
			end
		end
		reportTest("alu and back-pressure", errsBefore);
	endtask

	task automatic testUnknownOps();
		int errsBefore;
		errsBefore = errCount;
		beginProgram(16'hC000);
		for (int i = 0; i < 6; i++) begin
			emitImm(OP_LDA_IMM, randomByte());
			emitRaw(unlistedOps[i]); // Runs as a one byte NOP
			emitAbs(OP_STA_ABS, 16'h4000 + 16'(i));
		end
		emitHalt();
		runProgram(1'b1);
		reportTest("unknown opcodes", errsBefore);
	endtask

	initial begin
		phi0 = 1'b0;
		reset = 1'b1;
		stallEn = 1'b0;
		void'($urandom(32'hd941_f46a));
		testVectorAndJump();
		testLoads();
		testAlu();
		testUnknownOps();
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: core6502.f
+incdir+design
design/core6502_pkg.sv
design/CoreCtrlIf.sv
design/Dispatch.sv
design/Alu.sv
design/Regs.sv
design/Core6502.sv
tb/tbMemModel.sv
tb/tbCore6502.sv

// File: Makefile
# Verilator build and simulation of the 6502 core testbench
VERILATOR ?= verilator
TOP       ?= tbCore6502
FILELIST  ?= core6502.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation reported errors, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
